/* tagePredictor.f */
logic/tagePkg.sv
logic/tageFrontEnd.sv
logic/tageTable.sv
logic/tageBimodal.sv
logic/tageUpdateCtrl.sv
logic/tagePredictOut.sv
logic/tagePredictor.sv
verif/tageClock.sv
verif/tagePredictor_assert.sv
verif/tagePredictorTb.sv

/* Bender.yml */
package:
  name: tagePredictor

sources:
  - logic/tagePkg.sv
  - logic/tageFrontEnd.sv
  - logic/tageTable.sv
  - logic/tageBimodal.sv
  - logic/tageUpdateCtrl.sv
  - logic/tagePredictOut.sv
  - logic/tagePredictor.sv
  - target: test
    files:
      - verif/tageClock.sv
      - verif/tagePredictor_assert.sv
      - verif/tagePredictorTb.sv

/* verif/tagePredictorTb.sv */
`default_nettype none

module tagePredictorTb;
    timeunit 1ns;
    timeprecision 100ps;

    import tagePkg::*;

    logic     clk;
    logic     rst;
    logic     predValid;
    pcT       predPc;
    logic     updValid;
    pcT       updPc;
    logic     updTaken;
    logic     predOutValid;
    logic     predTaken;
    providerT predProvider;

    // reference state, index 0 is the short table and 1 the long one.
    ctrT                  refBim [tableEntries];
    tagT                  refTag [2][tableEntries];
    usefulT               refUse [2][tableEntries];
    ctrT                  refCtr [2][tableEntries];
    histT                 refHist;
    logic [decayBits-1:0] refDecay;

    logic     expValid;
    logic     expTaken;
    providerT expProvider;
    logic [15:0] lfsr;
    int       checks;
    int       errors;
    string    testName;

    localparam pcT pcB = 14'h2A15;
    localparam pcT pcC = 14'h1000;
    localparam pcT pcD = 14'h1C2A;
    localparam pcT pcE = 14'h3F15;

    tageClock clkGen (.clk);

    tagePredictor dut (
        .clk, .rst, .predValid, .predPc, .updValid, .updPc, .updTaken,
        .predOutValid, .predTaken, .predProvider
    );

    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // small pc pool so that tagged entries get reused.
    function automatic pcT pickPc();
        logic [2:0] hi;
        logic [2:0] lo;
        hi = 3'(randBits(3));
        lo = 3'(randBits(3));
        return {hi, 5'b00000, lo, 3'b011};
    endfunction

    function automatic int lenOf(input int t);
        return (t == 0) ? histLenShort : histLenLong;
    endfunction

    function automatic idxT indexFor(input pcT pc, input histT h, input int len);
        histT m;
        m = h & histT'((1 << len) - 1);
        return pc[5:0] ^ m[5:0] ^ {4'b0000, m[7:6]};
    endfunction

    function automatic tagT tagFor(input pcT pc, input histT h, input int len);
        histT m;
        m = h & histT'((1 << len) - 1);
        return pc[13:6] ^ m;
    endfunction

    function automatic logic [1:0] satMove(input logic [1:0] v, input logic up);
        if (up) begin
            return (v == 2'd3) ? v : v + 2'd1;
        end
        return (v == 2'd0) ? v : v - 2'd1;
    endfunction

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic modelEdge();
        idxT    qi [2];
        idxT    ui [2];
        tagT    qt [2];
        tagT    ut [2];
        logic   qh [2];
        logic   uh [2];
        usefulT oldU [2];
        ctrT    oldC [2];
        idxT    b;
        int     prov;
        int     p;
        logic   provT;
        logic   altT;
        logic   miss;
        logic   anyFree;
        if (rst) begin
            refHist = '0;
            refDecay = '0;
            expValid = 1'b0;
            for (int i = 0; i < tableEntries; i++) begin
                refBim[i] = ctrT'(1);
                for (int t = 0; t < 2; t++) begin
                    refTag[t][i] = '0;
                    refUse[t][i] = '0;
                    refCtr[t][i] = '0;
                end
            end
        end else begin
            for (int t = 0; t < 2; t++) begin
                qi[t] = indexFor(predPc, refHist, lenOf(t));
                qt[t] = tagFor(predPc, refHist, lenOf(t));
                ui[t] = indexFor(updPc, refHist, lenOf(t));
                ut[t] = tagFor(updPc, refHist, lenOf(t));
                qh[t] = refTag[t][qi[t]] == qt[t];
                uh[t] = refTag[t][ui[t]] == ut[t];
                oldU[t] = refUse[t][ui[t]];
                oldC[t] = refCtr[t][ui[t]];
            end
            expValid = predValid;
            if (predValid) begin
                if (qh[1]) begin
                    expProvider = 2'd2;
                    expTaken = refCtr[1][qi[1]][1];
                end else if (qh[0]) begin
                    expProvider = 2'd1;
                    expTaken = refCtr[0][qi[0]][1];
                end else begin
                    expProvider = 2'd0;
                    expTaken = refBim[predPc[5:0]][1];
                end
            end
            // aging first, the update below overrides its own entry.
            if (refDecay == '0) begin
                for (int t = 0; t < 2; t++) begin
                    for (int i = 0; i < tableEntries; i++) begin
                        if (refUse[t][i] != '0) begin
                            refUse[t][i] = refUse[t][i] - 1'b1;
                        end
                    end
                end
            end
            refDecay = refDecay - 1'b1;
            if (updValid) begin
                b = updPc[5:0];
                prov = uh[1] ? 2 : (uh[0] ? 1 : 0);
                p = prov - 1;
                altT = (prov == 2 && uh[0]) ? oldC[0][1] : refBim[b][1];
                if (prov == 0) begin
                    provT = refBim[b][1];
                end else begin
                    provT = oldC[p][1];
                end
                miss = provT != updTaken;
                if (prov == 0) begin
                    refBim[b] = satMove(refBim[b], updTaken);
                end else begin
                    refCtr[p][ui[p]] = satMove(oldC[p], updTaken);
                    if (provT != altT) begin
                        refUse[p][ui[p]] = satMove(oldU[p], !miss);
                    end
                end
                // tables longer than the provider.
                if (miss) begin
                    anyFree = 1'b0;
                    for (int t = prov; t < 2; t++) begin
                        anyFree = anyFree | (oldU[t] == '0);
                    end
                    for (int t = prov; t < 2; t++) begin
                        if (oldU[t] == '0) begin
                            refTag[t][ui[t]] = ut[t];
                            refCtr[t][ui[t]] = {updTaken, 1'b0};
                            refUse[t][ui[t]] = '0;
                        end else if (!anyFree) begin
                            refUse[t][ui[t]] = oldU[t] - 1'b1;
                        end
                    end
                end
                refHist = {refHist[6:0], updTaken};
            end
        end
    endtask

    task automatic checkOutputs();
        checkValue({testName, " predOutValid"}, expValid, predOutValid);
        if (expValid) begin
            checkValue({testName, " predTaken"}, expTaken, predTaken);
            checkValue({testName, " predProvider"}, expProvider, predProvider);
        end
    endtask

    // model steps on the edge, inputs change 2 ns later.
    task automatic tick();
        @(posedge clk);
        modelEdge();
        #2;
        checkOutputs();
    endtask

    task automatic finishRun();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic applyReset();
        rst = 1'b1;
        repeat (10) tick();
        rst = 1'b0;
    endtask

    task automatic queryPc(input pcT pc, output logic taken, output providerT prov);
        int waited;
        predValid = 1'b1;
        predPc = pc;
        tick();
        predValid = 1'b0;
        waited = 0;
        while (!predOutValid && waited < 4) begin
            tick();
            waited++;
        end
        if (!predOutValid) begin
            errors++;
            $display("timeout in %s, no prediction came back for pc %h", testName, pc);
            finishRun();
        end else begin
            taken = predTaken;
            prov = predProvider;
        end
    endtask

    task automatic expectQuery(input pcT pc, input int prov, input logic taken);
        logic     gotTaken;
        providerT gotProv;
        queryPc(pc, gotTaken, gotProv);
        checkValue({testName, " provider"}, prov, gotProv);
        checkValue({testName, " taken"}, taken, gotTaken);
    endtask

    task automatic updatePc(input pcT pc, input logic taken);
        updValid = 1'b1;
        updPc = pc;
        updTaken = taken;
        tick();
        updValid = 1'b0;
    endtask

    // correct not-taken updates of pcC, history ends at zero.
    task automatic flushHistory();
        repeat (8) updatePc(pcC, 1'b0);
    endtask

    initial begin
        rst = 1'b1;
        predValid = 1'b0;
        predPc = '0;
        updValid = 1'b0;
        updPc = '0;
        updTaken = 1'b0;
        lfsr = 16'd19;
        checks = 0;
        errors = 0;
        testName = "reset";
        applyReset();
        expectQuery(14'h0425, 0, 1'b0);
        // tag zero matches the cleared tags.
        expectQuery(14'h0011, 2, 1'b0);
        expectQuery(14'h3FC0, 0, 1'b0);

        testName = "bimodal";
        expectQuery(pcD, 0, 1'b0);
        updatePc(pcD, 1'b1);
        expectQuery(pcD, 0, 1'b1);
        updatePc(pcD, 1'b1);
        updatePc(pcD, 1'b1);
        updatePc(pcD, 1'b0);
        expectQuery(pcD, 0, 1'b1);

        testName = "alloc";
        applyReset();
        updatePc(pcB, 1'b1);
        flushHistory();
        expectQuery(pcB, 2, 1'b1);

        testName = "useful";
        updatePc(pcB, 1'b0);
        updatePc(pcB, 1'b0);
        expectQuery(pcB, 2, 1'b0);
        // long entry protected, short allocates.
        updatePc(pcE, 1'b0);
        // no free entry, so the long useful field drops.
        updatePc(pcE, 1'b1);
        flushHistory();
        expectQuery(pcB, 2, 1'b0);
        updatePc(pcE, 1'b1);
        flushHistory();
        expectQuery(pcE, 2, 1'b1);
        expectQuery(pcB, 0, 1'b0);

        testName = "decay";
        updatePc(pcE, 1'b0);
        updatePc(pcE, 1'b0);
        expectQuery(pcE, 2, 1'b0);
        repeat (1030) tick();
        updatePc(pcB, 1'b1);
        flushHistory();
        expectQuery(pcB, 2, 1'b1);

        testName = "random";
        applyReset();
        repeat (3000) begin
            predValid = 1'(randBits(1));
            predPc = pickPc();
            updValid = 1'(randBits(1));
            updPc = pickPc();
            updTaken = 1'(randBits(1));
            tick();
        end
        predValid = 1'b0;
        updValid = 1'b0;
        repeat (2) tick();
        finishRun();
    end

endmodule

`default_nettype wire

/* verif/tagePredictor_assert.sv */
`default_nettype none

module tagePredictor_assert (
    input logic              clk,
    input logic              rst,
    input logic              predValid,
    input logic              predOutValid,
    input tagePkg::providerT predProvider
);
    timeunit 1ns;
    timeprecision 100ps;

    import tagePkg::*;

    outValidAfterReset: assert property (@(posedge clk) rst |=> !predOutValid)
        else $error("predOutValid high in the cycle after a reset cycle");

    // one cycle latency, no back-pressure.
    outValidFollowsQuery: assert property (
        @(posedge clk) disable iff (rst) $past(!rst) |-> predOutValid == $past(predValid))
        else $error("predOutValid does not follow predValid of the previous cycle");

    providerInRange: assert property (
        @(posedge clk) disable iff (rst) predProvider != providerT'(3))
        else $error("predProvider is 3");

endmodule

bind tagePredictor tagePredictor_assert assertions (.*);

`default_nettype wire

/* verif/tageClock.sv */
`default_nettype none

module tageClock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period.
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

endmodule

`default_nettype wire

/* logic/tagePredictor.sv */
`default_nettype none

module tagePredictor (
    input  logic              clk,
    input  logic              rst,
    input  logic              predValid,
    input  tagePkg::pcT       predPc,
    input  logic              updValid,
    input  tagePkg::pcT       updPc,
    input  logic              updTaken,
    output logic              predOutValid,
    output logic              predTaken,
    output tagePkg::providerT predProvider
);
    import tagePkg::*;

    idxT  qBimIdx, uBimIdx;
    idxT  qIdxShort, qIdxLong, uIdxShort, uIdxLong;
    tagT  qTagShort, qTagLong, uTagShort, uTagLong;
    logic readHitShort, readTakenShort, readHitLong, readTakenLong;
    logic updHitShort, updTakenShort, updUsefulShort, allocShort;
    logic updHitLong, updTakenLong, updUsefulLong, allocLong;
    logic bimReadTaken, bimUpdTaken, bimWrite;
    logic writeValidShort, writeUpdateShort, writeNewShort, writeUsefulShort;
    logic writeValidLong, writeUpdateLong, writeNewLong, writeUsefulLong;
    logic writeTaken, anyAlloc;

    tageFrontEnd frontEnd (
        .clk, .rst, .predPc, .updPc, .updValid, .updTaken,
        .qBimIdx, .uBimIdx, .qIdxShort, .qIdxLong, .uIdxShort, .uIdxLong,
        .qTagShort, .qTagLong, .uTagShort, .uTagLong
    );

    tageTable #(.histLen(histLenShort)) shortTable (
        .clk, .rst,
        .readIdx(qIdxShort), .readTag(qTagShort),
        .readHit(readHitShort), .readTaken(readTakenShort),
        .writeIdx(uIdxShort), .writeTag(uTagShort),
        .writeValid(writeValidShort), .writeUpdate(writeUpdateShort),
        .writeNew(writeNewShort), .writeUseful(writeUsefulShort),
        .writeTaken, .anyAlloc,
        .updHit(updHitShort), .updTaken(updTakenShort),
        .updUseful(updUsefulShort), .alloc(allocShort)
    );

    tageTable #(.histLen(histLenLong)) longTable (
        .clk, .rst,
        .readIdx(qIdxLong), .readTag(qTagLong),
        .readHit(readHitLong), .readTaken(readTakenLong),
        .writeIdx(uIdxLong), .writeTag(uTagLong),
        .writeValid(writeValidLong), .writeUpdate(writeUpdateLong),
        .writeNew(writeNewLong), .writeUseful(writeUsefulLong),
        .writeTaken, .anyAlloc,
        .updHit(updHitLong), .updTaken(updTakenLong),
        .updUseful(updUsefulLong), .alloc(allocLong)
    );

    tageBimodal bimodal (
        .clk, .rst,
        .readIdx(qBimIdx), .readTaken(bimReadTaken),
        .writeIdx(uBimIdx), .writeValid(bimWrite), .writeTaken,
        .updTaken(bimUpdTaken)
    );

    tageUpdateCtrl updateCtrl (
        .updValid, .updTaken,
        .hitShort(updHitShort), .takenShort(updTakenShort),
        .usefulShort(updUsefulShort), .allocShort,
        .hitLong(updHitLong), .takenLong(updTakenLong),
        .usefulLong(updUsefulLong), .allocLong,
        .bimTaken(bimUpdTaken),
        .writeValidShort, .writeUpdateShort, .writeNewShort, .writeUsefulShort,
        .writeValidLong, .writeUpdateLong, .writeNewLong, .writeUsefulLong,
        .writeTaken, .anyAlloc, .bimWrite
    );

    tagePredictOut predictOut (
        .clk, .rst, .predValid,
        .hitShort(readHitShort), .takenShort(readTakenShort),
        .hitLong(readHitLong), .takenLong(readTakenLong),
        .bimTaken(bimReadTaken),
        .predOutValid, .predTaken, .predProvider
    );

endmodule

`default_nettype wire

/* logic/tagePredictOut.sv */
`default_nettype none

module tagePredictOut (
    input  logic              clk,
    input  logic              rst,
    input  logic              predValid,
    input  logic              hitShort,
    input  logic              takenShort,
    input  logic              hitLong,
    input  logic              takenLong,
    input  logic              bimTaken,
    output logic              predOutValid,
    output logic              predTaken,
    output tagePkg::providerT predProvider
);
    import tagePkg::*;

    providerT nextProvider;
    logic     nextTaken;

    always_comb begin
        if (hitLong) begin
            nextProvider = providerT'(2);
            nextTaken    = takenLong;
        end else if (hitShort) begin
            nextProvider = providerT'(1);
            nextTaken    = takenShort;
        end else begin
            nextProvider = providerT'(0);
            nextTaken    = bimTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            predOutValid <= 1'b0;
            predTaken    <= 1'b0;
            predProvider <= '0;
        end else begin
            predOutValid <= predValid;
            if (predValid) begin
                predTaken    <= nextTaken;
                predProvider <= nextProvider;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/tageUpdateCtrl.sv */
`default_nettype none

module tageUpdateCtrl (
    input  logic updValid,
    input  logic updTaken,
    input  logic hitShort,
    input  logic takenShort,
    input  logic usefulShort,
    input  logic allocShort,
    input  logic hitLong,
    input  logic takenLong,
    input  logic usefulLong,
    input  logic allocLong,
    input  logic bimTaken,
    output logic writeValidShort,
    output logic writeUpdateShort,
    output logic writeNewShort,
    output logic writeUsefulShort,
    output logic writeValidLong,
    output logic writeUpdateLong,
    output logic writeNewLong,
    output logic writeUsefulLong,
    output logic writeTaken,
    output logic anyAlloc,
    output logic bimWrite
);
    import tagePkg::*;

    providerT provider;
    logic     providerTaken;
    logic     providerUseful;
    logic     altTaken;
    logic     mispredict;
    logic     adjustUseful;

    // longest hit provides, next shorter hit is the alternate.
    always_comb begin
        if (hitLong) begin
            provider       = providerT'(2);
            providerTaken  = takenLong;
            providerUseful = usefulLong;
            altTaken       = hitShort ? takenShort : bimTaken;
        end else if (hitShort) begin
            provider       = providerT'(1);
            providerTaken  = takenShort;
            providerUseful = usefulShort;
            altTaken       = bimTaken;
        end else begin
            provider       = providerT'(0);
            providerTaken  = bimTaken;
            providerUseful = 1'b0;
            altTaken       = bimTaken;
        end
    end

    assign mispredict = providerTaken != updTaken;

    // only when the alternate disagreed; skip a decrement of an already zero field.
    assign adjustUseful = providerTaken != altTaken && (!mispredict || providerUseful);

    assign writeUpdateShort = provider == providerT'(1);
    assign writeUpdateLong  = provider == providerT'(2);

    // allocate into every table longer than the provider.
    assign writeNewShort = mispredict && provider == providerT'(0);
    assign writeNewLong  = mispredict && provider != providerT'(2);

    assign writeUsefulShort = writeUpdateShort && adjustUseful;
    assign writeUsefulLong  = writeUpdateLong && adjustUseful;

    assign writeValidShort = updValid && (writeUpdateShort || writeNewShort);
    assign writeValidLong  = updValid && (writeUpdateLong || writeNewLong);

    assign bimWrite   = updValid && provider == providerT'(0);
    assign writeTaken = updTaken;
    assign anyAlloc   = allocShort || allocLong;

endmodule

`default_nettype wire

/* logic/tageBimodal.sv */
`default_nettype none

module tageBimodal (
    input  logic         clk,
    input  logic         rst,
    input  tagePkg::idxT readIdx,
    output logic         readTaken,
    input  tagePkg::idxT writeIdx,
    input  logic         writeValid,
    input  logic         writeTaken,
    output logic         updTaken
);
    import tagePkg::*;

    ctrT ctr [tableEntries];

    assign readTaken = ctr[readIdx][1];
    assign updTaken  = ctr[writeIdx][1];

    always_ff @(posedge clk) begin
        if (rst) begin
            // weakly not taken.
            for (int i = 0; i < tableEntries; i++) begin
                ctr[i] <= ctrT'(1);
            end
        end else if (writeValid) begin
            if (writeTaken && ctr[writeIdx] != '1) begin
                ctr[writeIdx] <= ctr[writeIdx] + 1'b1;
            end else if (!writeTaken && ctr[writeIdx] != '0) begin
                ctr[writeIdx] <= ctr[writeIdx] - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/tageTable.sv */
`default_nettype none

module tageTable #(
    parameter int histLen = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  tagePkg::idxT readIdx,
    input  tagePkg::tagT readTag,
    output logic         readHit,
    output logic         readTaken,
    input  tagePkg::idxT writeIdx,
    input  tagePkg::tagT writeTag,
    input  logic         writeValid,
    input  logic         writeUpdate,
    input  logic         writeNew,
    input  logic         writeUseful,
    input  logic         writeTaken,
    input  logic         anyAlloc,
    output logic         updHit,
    output logic         updTaken,
    output logic         updUseful,
    output logic         alloc
);
    import tagePkg::*;

    tagT    tags   [tableEntries];
    usefulT useful [tableEntries];
    ctrT    ctr    [tableEntries];

    logic [decayBits-1:0] decayCnt;
    usefulT               nextUseful;
    logic                 providerCorrect;

    if (histLen < 1 || histLen > $bits(histT)) begin : gBadHistLen
        $error("tageTable: histLen %0d out of range", histLen);
    end

    assign readHit   = tags[readIdx] == readTag;
    assign readTaken = ctr[readIdx][1];

    assign updHit    = tags[writeIdx] == writeTag;
    assign updTaken  = ctr[writeIdx][1];
    assign updUseful = useful[writeIdx] != '0;

    // a free slot is one whose useful field has reached zero.
    assign alloc = writeValid && !writeUpdate && writeNew && useful[writeIdx] == '0;

    // the table itself knows whether it predicted right.
    assign providerCorrect = ctr[writeIdx][1] == writeTaken;

    always_comb begin
        nextUseful = useful[writeIdx];
        if (providerCorrect && useful[writeIdx] != '1) begin
            nextUseful = useful[writeIdx] + 1'b1;
        end else if (!providerCorrect && useful[writeIdx] != '0) begin
            nextUseful = useful[writeIdx] - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decayCnt <= '0;
            for (int i = 0; i < tableEntries; i++) begin
                tags[i]   <= '0;
                useful[i] <= '0;
                ctr[i]    <= '0;
            end
        end else begin
            decayCnt <= decayCnt - 1'b1;
            // aging first, a write below overrides it.
            if (decayCnt == '0) begin
                for (int i = 0; i < tableEntries; i++) begin
                    if (useful[i] != '0) begin
                        useful[i] <= useful[i] - 1'b1;
                    end
                end
            end
            if (writeValid && writeUpdate) begin
                if (writeTaken && ctr[writeIdx] != '1) begin
                    ctr[writeIdx] <= ctr[writeIdx] + 1'b1;
                end else if (!writeTaken && ctr[writeIdx] != '0) begin
                    ctr[writeIdx] <= ctr[writeIdx] - 1'b1;
                end
                if (writeUseful) begin
                    useful[writeIdx] <= nextUseful;
                end
            end else if (writeValid && writeNew) begin
                if (useful[writeIdx] == '0) begin
                    tags[writeIdx]   <= writeTag;
                    ctr[writeIdx]    <= {writeTaken, 1'b0};
                    useful[writeIdx] <= '0;
                end else if (!anyAlloc) begin
                    useful[writeIdx] <= useful[writeIdx] - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/tageFrontEnd.sv */
`default_nettype none

module tageFrontEnd (
    input  logic         clk,
    input  logic         rst,
    input  tagePkg::pcT  predPc,
    input  tagePkg::pcT  updPc,
    input  logic         updValid,
    input  logic         updTaken,
    output tagePkg::idxT qBimIdx,
    output tagePkg::idxT uBimIdx,
    output tagePkg::idxT qIdxShort,
    output tagePkg::idxT qIdxLong,
    output tagePkg::idxT uIdxShort,
    output tagePkg::idxT uIdxLong,
    output tagePkg::tagT qTagShort,
    output tagePkg::tagT qTagLong,
    output tagePkg::tagT uTagShort,
    output tagePkg::tagT uTagLong
);
    import tagePkg::*;

    histT hist;

    // low len bits of history, the rest zero.
    function automatic histT maskHist(input histT h, input int len);
        return h & histT'((16'd1 << len) - 16'd1);
    endfunction

    // upper two history bits fold back onto the index.
    function automatic idxT hashIdx(input pcT pc, input histT h, input int len);
        histT m;
        m = maskHist(h, len);
        return pc[5:0] ^ m[5:0] ^ idxT'(m[7:6]);
    endfunction

    function automatic tagT hashTag(input pcT pc, input histT h, input int len);
        return pc[13:6] ^ maskHist(h, len);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            hist <= '0;
        end else if (updValid) begin
            hist <= {hist[$bits(histT)-2:0], updTaken};
        end
    end

    assign qBimIdx   = predPc[5:0];
    assign uBimIdx   = updPc[5:0];
    assign qIdxShort = hashIdx(predPc, hist, histLenShort);
    assign qIdxLong  = hashIdx(predPc, hist, histLenLong);
    assign uIdxShort = hashIdx(updPc, hist, histLenShort);
    assign uIdxLong  = hashIdx(updPc, hist, histLenLong);
    assign qTagShort = hashTag(predPc, hist, histLenShort);
    assign qTagLong  = hashTag(predPc, hist, histLenLong);
    assign uTagShort = hashTag(updPc, hist, histLenShort);
    assign uTagLong  = hashTag(updPc, hist, histLenLong);

endmodule

`default_nettype wire

/* logic/tagePkg.sv */
`default_nettype none

package tagePkg;

    // branch address and table addressing.
    typedef logic [13:0] pcT;
    typedef logic [5:0]  idxT;
    typedef logic [7:0]  tagT;

    // top bit of the counter is the predicted direction.
    typedef logic [1:0] ctrT;
    typedef logic [1:0] usefulT;

    // bit 0 holds the newest outcome.
    typedef logic [7:0] histT;

    // 0 bimodal, 1 short table, 2 long table.
    typedef logic [1:0] providerT;

    localparam int tableEntries = 64;
    localparam int histLenShort = 4;
    localparam int histLenLong  = 8;

    // aging period is 2**decayBits cycles.
    localparam int decayBits = 10;

endpackage

`default_nettype wire
